// ==== rtl/striped_fifo_pkg.sv ====
// ---------------------------------------------------------
// shared sizes and credit counts of the striped FWFT FIFO
// ---------------------------------------------------------
`default_nettype none

package striped_fifo_pkg;

   // ---------------------------------------------------------
   // lane striping
   // ---------------------------------------------------------
   // lane count, kept a power of two so the lane index wraps
   localparam int unsigned NUM_LANES  = 4;
   localparam int unsigned LANE_IDX_W = 2;

   // word width
   localparam int unsigned DATA_W     = 16;

   // ---------------------------------------------------------
   // per lane storage
   // ---------------------------------------------------------
   localparam int unsigned LANE_DEPTH = 8;
   // address bits, pointers carry one extra wrap bit
   localparam int unsigned LANE_AW    = 3;

   // ---------------------------------------------------------
   // credit flow control
   // ---------------------------------------------------------
   // upstream grant covers every memory slot of every lane
   localparam int unsigned UP_CREDITS = NUM_LANES * LANE_DEPTH;
   // shared width of all credit counters
   localparam int unsigned UP_CNT_W   = 6;
   // slots the sink offers after reset
   localparam int unsigned DN_CREDITS = 4;

endpackage : striped_fifo_pkg

`default_nettype wire

// ==== rtl/word_distributor.sv ====
// ---------------------------------------------------------
// round-robin write steering and upstream credit issue
// ---------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module word_distributor (
   input  logic                                pos_rclk,
   input  logic                                aresetn_rclk,
   input  logic                                up_valid,
   input  logic [striped_fifo_pkg::DATA_W-1:0]    up_data,
   input  logic                                pop,
   output logic                                up_credit,
   output logic [striped_fifo_pkg::NUM_LANES-1:0] lane_wr_en,
   output logic [striped_fifo_pkg::DATA_W-1:0]    lane_wr_data
);
   import striped_fifo_pkg::*;

   // lane that takes the next accepted word
   logic [LANE_IDX_W-1:0] wr_idx;
   // credits of the initial grant still to go out
   logic [UP_CNT_W-1:0]   grant_cnt;
   // returned credits waiting for a free pulse slot
   logic [UP_CNT_W-1:0]   pend_cnt;

   // ---------------------------------------------------------
   // write steering
   // ---------------------------------------------------------
   // one-hot enable, same cycle as up_valid
   always_comb begin
      for (int i = 0; i < NUM_LANES; i++) begin
         lane_wr_en[i] = up_valid && (wr_idx == LANE_IDX_W'(i));
      end
   end

   // data is shared by all lanes
   assign lane_wr_data = up_data;

   always_ff @(posedge pos_rclk or negedge aresetn_rclk) begin
      if (!aresetn_rclk) begin
         wr_idx <= '0;
      end else if (up_valid) begin
         // wraps after the last lane
         wr_idx <= wr_idx + 1'b1;
      end
   end

   // ---------------------------------------------------------
   // upstream credits
   // ---------------------------------------------------------
   // at most one pulse per cycle, the grant goes first
   always_ff @(posedge pos_rclk or negedge aresetn_rclk) begin
      if (!aresetn_rclk) begin
         grant_cnt <= UP_CNT_W'(UP_CREDITS);
         pend_cnt  <= '0;
         up_credit <= 1'b0;
      end else if (grant_cnt != '0) begin
         // initial grant running, park any pop
         grant_cnt <= grant_cnt - 1'b1;
         up_credit <= 1'b1;
         if (pop) begin
            pend_cnt <= pend_cnt + 1'b1;
         end
      end else if (pend_cnt != '0) begin
         // drain the backlog, a new pop replaces the one sent
         up_credit <= 1'b1;
         if (!pop) begin
            pend_cnt <= pend_cnt - 1'b1;
         end
      end else begin
         // nothing parked, a pop goes straight back out
         up_credit <= pop;
      end
   end

endmodule : word_distributor

`default_nettype wire

// ==== rtl/fwft_stage.sv ====
// ---------------------------------------------------------
// prefetch chain (fifo, middle, dout) that hides the
// one-cycle memory read latency behind an FWFT output
// ---------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fwft_stage (
   input  logic                             pos_rclk,
   input  logic                             aresetn_rclk,
   input  logic                             fifo_empty,
   input  logic [striped_fifo_pkg::DATA_W-1:0] fifo_dout,
   output logic                             fifo_rd_en,
   input  logic                             rd_en,
   output logic [striped_fifo_pkg::DATA_W-1:0] dout,
   output logic                             dout_valid
);
   import striped_fifo_pkg::*;

   // fifo_valid: memory read data register holds a word
   logic              fifo_valid;
   // middle slot, catches data while dout is occupied
   logic              middle_valid;
   logic [DATA_W-1:0] middle_dout;

   logic              update_dout;
   logic              update_middle;

   // ---------------------------------------------------------
   // slot moves
   // ---------------------------------------------------------
   // output loads when something is behind it and the slot
   // is free or being read this cycle
   assign update_dout = (fifo_valid || middle_valid) && (rd_en || !dout_valid);

   // middle loads from memory data when
   //   middle empty and dout not loading: park the word
   //   middle full and dout loading from middle: shift up
   assign update_middle = fifo_valid && (middle_valid == update_dout);

   // ---------------------------------------------------------
   // memory read request
   // ---------------------------------------------------------
   // keep fetching until all three slots hold a word
   assign fifo_rd_en = !fifo_empty && !(fifo_valid && middle_valid && dout_valid);

   // ---------------------------------------------------------
   // valid flags
   // ---------------------------------------------------------
   always_ff @(posedge pos_rclk or negedge aresetn_rclk) begin
      if (!aresetn_rclk) begin
         fifo_valid <= 1'b0;
      end else if (fifo_rd_en) begin
         // new word arrives next cycle, old one moved on
         fifo_valid <= 1'b1;
      end else if (update_middle || update_dout) begin
         fifo_valid <= 1'b0;
      end
   end

   always_ff @(posedge pos_rclk or negedge aresetn_rclk) begin
      if (!aresetn_rclk) begin
         middle_valid <= 1'b0;
      end else if (update_middle) begin
         middle_valid <= 1'b1;
      end else if (update_dout) begin
         // middle word went to the output
         middle_valid <= 1'b0;
      end
   end

   always_ff @(posedge pos_rclk or negedge aresetn_rclk) begin
      if (!aresetn_rclk) begin
         dout_valid <= 1'b0;
      end else if (update_dout) begin
         dout_valid <= 1'b1;
      end else if (rd_en) begin
         dout_valid <= 1'b0;
      end
   end

   // ---------------------------------------------------------
   // data registers
   // ---------------------------------------------------------
   always_ff @(posedge pos_rclk) begin
      if (update_middle) begin
         middle_dout <= fifo_dout;
      end
   end

   // middle is older than memory data, so it goes first
   always_ff @(posedge pos_rclk) begin
      if (update_dout) begin
         dout <= middle_valid ? middle_dout : fifo_dout;
      end
   end

endmodule : fwft_stage

`default_nettype wire

// ==== rtl/fifo_lane.sv ====
// ---------------------------------------------------------
// one storage lane: memory, pointers, registered read port
// and the FWFT stage in front of the merger
// ---------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fifo_lane (
   input  logic                             pos_rclk,
   input  logic                             aresetn_rclk,
   input  logic                             wr_en,
   input  logic [striped_fifo_pkg::DATA_W-1:0] wr_data,
   input  logic                             rd_en,
   output logic [striped_fifo_pkg::DATA_W-1:0] lane_data,
   output logic                             lane_dvld
);
   import striped_fifo_pkg::*;

   // storage array
   logic [DATA_W-1:0] mem [LANE_DEPTH];

   // pointers, top bit is the wrap flag
   logic [LANE_AW:0]  wr_ptr;
   logic [LANE_AW:0]  rd_ptr;

   // registered read data towards the stage
   logic [DATA_W-1:0] rd_data;

   logic              empty;
   logic              fifo_rd_en;

   // ---------------------------------------------------------
   // pointers and status
   // ---------------------------------------------------------
   // equal pointers incl. wrap bit mean empty
   // a full lane has the same low bits but a different wrap bit
   assign empty = (wr_ptr == rd_ptr);

   always_ff @(posedge pos_rclk or negedge aresetn_rclk) begin
      if (!aresetn_rclk) begin
         wr_ptr <= '0;
      end else if (wr_en) begin
         wr_ptr <= wr_ptr + 1'b1;
      end
   end

   // read side advances on the stage request only
   always_ff @(posedge pos_rclk or negedge aresetn_rclk) begin
      if (!aresetn_rclk) begin
         rd_ptr <= '0;
      end else if (fifo_rd_en) begin
         rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // ---------------------------------------------------------
   // memory array
   // ---------------------------------------------------------
   // no overflow check, occupancy is bounded by the
   // upstream credit grant
   always_ff @(posedge pos_rclk) begin
      if (wr_en) begin
         mem[wr_ptr[LANE_AW-1:0]] <= wr_data;
      end
   end

   // one cycle read latency
   // rd_data holds its word until the next fifo_rd_en
   always_ff @(posedge pos_rclk) begin
      if (fifo_rd_en) begin
         rd_data <= mem[rd_ptr[LANE_AW-1:0]];
      end
   end

   // ---------------------------------------------------------
   // FWFT stage
   // ---------------------------------------------------------
   fwft_stage i_fwft_stage (
      .pos_rclk     (pos_rclk),
      .aresetn_rclk (aresetn_rclk),
      .fifo_empty   (empty),
      .fifo_dout    (rd_data),
      .fifo_rd_en   (fifo_rd_en),
      .rd_en        (rd_en),
      .dout         (lane_data),
      .dout_valid   (lane_dvld)
   );

endmodule : fifo_lane

`default_nettype wire

// ==== rtl/lane_merger.sv ====
// ---------------------------------------------------------
// in-order lane drain under downstream credits
// ---------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module lane_merger (
   input  logic                                pos_rclk,
   input  logic                                aresetn_rclk,
   input  logic [striped_fifo_pkg::DATA_W-1:0]    lane_data [striped_fifo_pkg::NUM_LANES],
   input  logic [striped_fifo_pkg::NUM_LANES-1:0] lane_dvld,
   input  logic                                dn_credit,
   output logic [striped_fifo_pkg::NUM_LANES-1:0] lane_rd_en,
   output logic                                pop,
   output logic                                dn_valid,
   output logic [striped_fifo_pkg::DATA_W-1:0]    dn_data
);
   import striped_fifo_pkg::*;

   // lane holding the next word in order
   logic [LANE_IDX_W-1:0] rd_idx;
   // downstream slots currently held
   logic [UP_CNT_W-1:0]   dn_cnt;
   logic                  take;

   // ---------------------------------------------------------
   // take decision
   // ---------------------------------------------------------
   // only the lane in turn may go, others wait even if ready
   assign take = lane_dvld[rd_idx] && (dn_cnt != '0);

   // FWFT read strobe, same cycle as the take
   always_comb begin
      for (int i = 0; i < NUM_LANES; i++) begin
         lane_rd_en[i] = take && (rd_idx == LANE_IDX_W'(i));
      end
   end

   always_ff @(posedge pos_rclk or negedge aresetn_rclk) begin
      if (!aresetn_rclk) begin
         rd_idx <= '0;
      end else if (take) begin
         rd_idx <= rd_idx + 1'b1;
      end
   end

   // ---------------------------------------------------------
   // downstream credit count
   // ---------------------------------------------------------
   always_ff @(posedge pos_rclk or negedge aresetn_rclk) begin
      if (!aresetn_rclk) begin
         dn_cnt <= UP_CNT_W'(DN_CREDITS);
      end else if (take && !dn_credit) begin
         dn_cnt <= dn_cnt - 1'b1;
      end else if (dn_credit && !take) begin
         dn_cnt <= dn_cnt + 1'b1;
      end
      // take with a return in the same cycle: no change
   end

   // ---------------------------------------------------------
   // output register
   // ---------------------------------------------------------
   // pop goes with dn_valid, one per word sent
   always_ff @(posedge pos_rclk or negedge aresetn_rclk) begin
      if (!aresetn_rclk) begin
         dn_valid <= 1'b0;
         pop      <= 1'b0;
      end else begin
         dn_valid <= take;
         pop      <= take;
      end
   end

   always_ff @(posedge pos_rclk) begin
      if (take) begin
         dn_data <= lane_data[rd_idx];
      end
   end

endmodule : lane_merger

`default_nettype wire

// ==== rtl/striped_fifo_top.sv ====
// ---------------------------------------------------------
// top level: distributor, lane array and merger
// ---------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module striped_fifo_top (
   input  logic                             pos_rclk,
   input  logic                             aresetn_rclk,
   input  logic                             up_valid,
   input  logic [striped_fifo_pkg::DATA_W-1:0] up_data,
   output logic                             up_credit,
   output logic                             dn_valid,
   output logic [striped_fifo_pkg::DATA_W-1:0] dn_data,
   input  logic                             dn_credit
);
   import striped_fifo_pkg::*;

   // write side
   logic [NUM_LANES-1:0] lane_wr_en;
   logic [DATA_W-1:0]    lane_wr_data;

   // read side
   logic [NUM_LANES-1:0] lane_rd_en;
   logic [NUM_LANES-1:0] lane_dvld;
   logic [DATA_W-1:0]    lane_data [NUM_LANES];

   // word left downstream, returns an upstream credit
   logic                 pop;

   word_distributor i_word_distributor (
      .pos_rclk     (pos_rclk),
      .aresetn_rclk (aresetn_rclk),
      .up_valid     (up_valid),
      .up_data      (up_data),
      .pop          (pop),
      .up_credit    (up_credit),
      .lane_wr_en   (lane_wr_en),
      .lane_wr_data (lane_wr_data)
   );

   // ---------------------------------------------------------
   // storage lanes
   // ---------------------------------------------------------
   for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
      fifo_lane i_fifo_lane (
         .pos_rclk     (pos_rclk),
         .aresetn_rclk (aresetn_rclk),
         .wr_en        (lane_wr_en[g]),
         .wr_data      (lane_wr_data),
         .rd_en        (lane_rd_en[g]),
         .lane_data    (lane_data[g]),
         .lane_dvld    (lane_dvld[g])
      );
   end

   lane_merger i_lane_merger (
      .pos_rclk     (pos_rclk),
      .aresetn_rclk (aresetn_rclk),
      .lane_data    (lane_data),
      .lane_dvld    (lane_dvld),
      .dn_credit    (dn_credit),
      .lane_rd_en   (lane_rd_en),
      .pop          (pop),
      .dn_valid     (dn_valid),
      .dn_data      (dn_data)
   );

endmodule : striped_fifo_top

`default_nettype wire

// ==== tb/striped_fifo_assertions.sv ====
// ---------------------------------------------------------
// credit and lane strobe protocol properties bound to top
// ---------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module striped_fifo_assertions (
   input logic                                pos_rclk,
   input logic                                aresetn_rclk,
   input logic                                up_valid,
   input logic [striped_fifo_pkg::NUM_LANES-1:0] lane_wr_en,
   input logic [striped_fifo_pkg::NUM_LANES-1:0] lane_rd_en,
   input logic                                dn_valid,
   input logic                                dn_credit
);
   import striped_fifo_pkg::*;

   // beats and returns seen on earlier edges
   int unsigned beats;
   int unsigned returns;
   // lane due for the next write and for the next read
   logic [LANE_IDX_W-1:0] wr_turn;
   logic [LANE_IDX_W-1:0] rd_turn;

   always_ff @(posedge pos_rclk or negedge aresetn_rclk) begin
      if (!aresetn_rclk) begin
         beats   <= 0;
         returns <= 0;
         wr_turn <= '0;
         rd_turn <= '0;
      end else begin
         if (dn_valid) beats <= beats + 1;
         if (dn_credit) returns <= returns + 1;
         if (up_valid) wr_turn <= wr_turn + 1'b1;
         if (|lane_rd_en) rd_turn <= rd_turn + 1'b1;
      end
   end

   // a beat needs a slot left over from the grant plus returns
   dn_valid_has_credit: assert property (@(posedge pos_rclk) disable iff (!aresetn_rclk)
      dn_valid |-> (beats < DN_CREDITS + returns))
      else $error("dn_valid without a downstream credit");

   // writes only with up_valid and on the lane in turn
   lane_write_needs_valid: assert property (@(posedge pos_rclk) disable iff (!aresetn_rclk)
      lane_wr_en == (up_valid ? NUM_LANES'(1) << wr_turn : NUM_LANES'(0)))
      else $error("lane write enable not matching up_valid and the lane in turn");

   // merger serves one lane at a time and in turn
   single_lane_read: assert property (@(posedge pos_rclk) disable iff (!aresetn_rclk)
      (|lane_rd_en) |-> (lane_rd_en == NUM_LANES'(1) << rd_turn))
      else $error("lane read enable not a single strobe on the lane in turn");

endmodule : striped_fifo_assertions

bind striped_fifo_top striped_fifo_assertions i_striped_fifo_assertions (
   .pos_rclk     (pos_rclk),
   .aresetn_rclk (aresetn_rclk),
   .up_valid     (up_valid),
   .lane_wr_en   (lane_wr_en),
   .lane_rd_en   (lane_rd_en),
   .dn_valid     (dn_valid),
   .dn_credit    (dn_credit)
);

`default_nettype wire

// ==== tb/striped_fifo_tb.sv ====
// ---------------------------------------------------------
// random credit source and sink around the striped FIFO,
// in-order queue model and credit accounting checks
// ---------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module striped_fifo_tb;
   import striped_fifo_pkg::*;

   localparam int NUM_WORDS = 2000;

   // DUT ports
   logic              pos_rclk;
   logic              aresetn_rclk;
   logic              up_valid;
   logic [DATA_W-1:0] up_data;
   logic              up_credit;
   logic              dn_valid;
   logic [DATA_W-1:0] dn_data;
   logic              dn_credit;

   integer            seed;
   logic [DATA_W-1:0] next_word;
   // credits the source holds right now
   int                src_credits;
   // event counts sampled on the falling edge
   int                credit_total;
   int                sent;
   int                delivered;
   int                returned;
   bit                src_en;
   bit                sink_en;
   // words sent and not yet seen downstream with the oldest at the front
   logic [DATA_W-1:0] model_q[$];

   striped_fifo_top i_striped_fifo_top (
      .pos_rclk     (pos_rclk),
      .aresetn_rclk (aresetn_rclk),
      .up_valid     (up_valid),
      .up_data      (up_data),
      .up_credit    (up_credit),
      .dn_valid     (dn_valid),
      .dn_data      (dn_data),
      .dn_credit    (dn_credit)
   );

   always #50 pos_rclk = ~pos_rclk;

   task automatic stop_on_failure(input string msg);
      $display("%s", msg);
      $display("CHECKS FAILED");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string name, input int got, input int exp);
      stop_on_failure($sformatf("[ERROR] t=%0t %s: got %0d (0x%0h) expected %0d (0x%0h)",
                                $time, name, got, got, exp, exp));
   endtask

   // ---------------------------------------------------------
   // stimulus on the rising edge
   // ---------------------------------------------------------
   always @(posedge pos_rclk) begin
      if (aresetn_rclk) begin
         // source spends a held credit on about 3 of 4 cycles
         if (src_en && src_credits > 0 && sent < NUM_WORDS && ($random(seed) & 3) != 0) begin
            next_word = $random(seed);
            up_valid <= 1'b1;
            up_data  <= next_word;
            model_q.push_back(next_word);
            src_credits--;
         end else begin
            up_valid <= 1'b0;
         end
         // sink gives back a slot after a random delay
         if (sink_en && (delivered - returned) > 0 && ($random(seed) & 1) != 0) begin
            dn_credit <= 1'b1;
         end else begin
            dn_credit <= 1'b0;
         end
      end
   end

   // ---------------------------------------------------------
   // monitor and model compare on the falling edge
   // ---------------------------------------------------------
   always @(negedge pos_rclk) begin
      if (aresetn_rclk) begin
         if (up_credit) begin
            src_credits++;
            credit_total++;
         end
         if (up_valid) begin
            sent++;
         end
         if (dn_credit) begin
            returned++;
         end
         if (dn_valid) begin
            assert (model_q.size() > 0)
               else stop_on_failure("dn_valid seen with no word left in the model queue");
            assert (dn_data == model_q[0])
               else report_mismatch("dn_data", dn_data, model_q[0]);
            void'(model_q.pop_front());
            delivered++;
            // beats bounded by the initial slots plus returns
            assert (delivered <= DN_CREDITS + returned)
               else report_mismatch("dn_valid beats", delivered, DN_CREDITS + returned);
         end
      end
   end

   // ---------------------------------------------------------
   // test sequence
   // ---------------------------------------------------------
   initial begin
      int waited;
      seed         = 32'h8fb8_c36c;
      pos_rclk     = 1'b0;
      aresetn_rclk = 1'b0;
      up_valid     = 1'b0;
      up_data      = '0;
      dn_credit    = 1'b0;
      src_credits  = 0;
      credit_total = 0;
      sent         = 0;
      delivered    = 0;
      returned     = 0;
      src_en       = 1'b0;
      sink_en      = 1'b0;
      repeat (2) @(posedge pos_rclk);
      aresetn_rclk <= 1'b1;

      // outputs quiet right after release
      @(negedge pos_rclk);
      assert (dn_valid == 1'b0) else report_mismatch("dn_valid", dn_valid, 0);
      assert (up_credit == 1'b0) else report_mismatch("up_credit", up_credit, 0);

      // initial grant with the source idle
      waited = 0;
      while (credit_total < UP_CREDITS) begin
         @(posedge pos_rclk);
         waited++;
         if (waited > 200) stop_on_failure("initial upstream credit grant never completed");
      end
      repeat (20) @(posedge pos_rclk);
      assert (credit_total == UP_CREDITS)
         else report_mismatch("up_credit pulses", credit_total, UP_CREDITS);

      // back-pressure with the sink holding every slot
      @(negedge pos_rclk);
      src_en = 1'b1;
      waited = 0;
      while (sent < UP_CREDITS + DN_CREDITS) begin
         @(posedge pos_rclk);
         waited++;
         if (waited > 1000) begin
            stop_on_failure("source could not spend its credits under back-pressure");
         end
      end
      repeat (40) @(posedge pos_rclk);
      assert (credit_total == UP_CREDITS + DN_CREDITS)
         else report_mismatch("up_credit pulses", credit_total, UP_CREDITS + DN_CREDITS);
      assert (delivered == DN_CREDITS) else report_mismatch("dn_valid beats", delivered, DN_CREDITS);

      // release the sink and run random traffic to the end
      @(negedge pos_rclk);
      sink_en = 1'b1;
      waited = 0;
      while (delivered < NUM_WORDS) begin
         @(posedge pos_rclk);
         waited++;
         if (waited > 20000) stop_on_failure("not all words came out downstream");
      end
      waited = 0;
      while (credit_total < UP_CREDITS + delivered) begin
         @(posedge pos_rclk);
         waited++;
         if (waited > 20) stop_on_failure("upstream credits for delivered words never returned");
      end
      repeat (10) @(posedge pos_rclk);
      assert (credit_total == UP_CREDITS + delivered)
         else report_mismatch("up_credit pulses", credit_total, UP_CREDITS + delivered);
      assert (model_q.size() == 0) else report_mismatch("model queue size", model_q.size(), 0);

      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule : striped_fifo_tb

`default_nettype wire

// ==== filelist.f ====
rtl/striped_fifo_pkg.sv
rtl/word_distributor.sv
rtl/fwft_stage.sv
rtl/fifo_lane.sv
rtl/lane_merger.sv
rtl/striped_fifo_top.sv
tb/striped_fifo_assertions.sv
tb/striped_fifo_tb.sv

// ==== Bender.yml ====
package:
  name: striped_fifo

sources:
  # design, in compile order
  - rtl/striped_fifo_pkg.sv
  - rtl/word_distributor.sv
  - rtl/fwft_stage.sv
  - rtl/fifo_lane.sv
  - rtl/lane_merger.sv
  - rtl/striped_fifo_top.sv
  # testbench
  - target: test
    files:
      - tb/striped_fifo_assertions.sv
      - tb/striped_fifo_tb.sv
